//--- design/frame_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared sizes, command codes and bit positions for the control-input
// frame. Every design file refers to these by frame_pkg:: names.
//////////////////////////////////////////////////////////////////////

package frame_pkg;

    // Sizes and counts
    localparam int NPADS    = 4;
    localparam int RAW_W    = 16;
    localparam int JOY_W    = 10;
    localparam int STATUS_W = 32;

    // Data bytes that follow each command code
    localparam int JOY_BYTES    = 2;
    localparam int STATUS_BYTES = 4;

    // Command codes of players 2 to 4 follow CMD_JOY0 in order
    localparam logic [7:0] CMD_JOY0   = 8'h02;
    localparam logic [7:0] CMD_STATUS = 8'h1E;

    // Raw joystick bits are all active high
    localparam int JB_RIGHT   = 0;
    localparam int JB_LEFT    = 1;
    localparam int JB_DOWN    = 2;
    localparam int JB_UP      = 3;
    localparam int JB_BUT0    = 4;
    localparam int JB_START   = 10;
    localparam int JB_COIN    = 11;
    localparam int JB_SERVICE = 12;

    // Status word bits
    localparam int ST_FM      = 0;
    localparam int ST_PSG     = 1;
    localparam int ST_TEST    = 2;
    localparam int ST_PAUSE   = 3;
    localparam int ST_FLIP    = 4;
    localparam int ST_ROTATE  = 5;
    // Low bit of the two-bit effects level
    localparam int ST_FXLEVEL = 6;

    // Game side
    localparam int BUTTONS         = 4;
    localparam bit GAME_ACTIVE_LOW = 1'b1;

    // Game reset length in clk_sys cycles
    localparam int RST_CYCLES = 16;
    localparam int RST_CNT_W  = $clog2(RST_CYCLES + 1);

    typedef logic [RAW_W-1:0]    joy_raw_t;
    typedef logic [JOY_W-1:0]    joy_game_t;
    typedef logic [STATUS_W-1:0] status_t;

endpackage

//--- design/pad_if.sv
//////////////////////////////////////////////////////////////////////
// One player's joystick path, from the raw word to the game format.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

interface pad_if;

    frame_pkg::joy_raw_t  raw;
    // Conditioned outputs in the game's polarity
    frame_pkg::joy_game_t joy;
    logic                 coin;
    logic                 start;
    logic                 service;

    modport rx (
        output raw
    );

    modport pad (
        input  raw,
        output joy,
        output coin,
        output start,
        output service
    );

    modport board (
        input joy,
        input coin,
        input start,
        input service
    );

endinterface

//--- design/io_cmd_rx.sv
//////////////////////////////////////////////////////////////////////
// Command decoder for the byte stream from the I/O controller. Holds
// the four raw joystick words and the status word.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module io_cmd_rx (
    input  logic              clk_sys,
    input  logic              rst_n,
    input  logic [7:0]        io_data,
    input  logic              io_strobe,
    input  logic              io_frame,
    pad_if.rx                 pads [frame_pkg::NPADS],
    output frame_pkg::status_t status
);

    localparam int SEL_W = $clog2(frame_pkg::NPADS);

    typedef enum logic [1:0] {
        S_CMD,
        S_DATA,
        S_SKIP
    } rx_state_t;

    rx_state_t            state;
    logic [1:0]           byte_cnt;
    logic                 is_status;
    logic [SEL_W-1:0]     pad_sel;
    frame_pkg::status_t   shift_q;
    frame_pkg::status_t   shift_nx;
    logic [7:0]           joy_idx;
    logic                 cmd_joy;
    logic                 cmd_status;
    logic                 last_byte;
    frame_pkg::joy_raw_t  joy_q [frame_pkg::NPADS];

    // Bytes arrive LSB first, so shift in from the top
    assign shift_nx   = {io_data, shift_q[frame_pkg::STATUS_W-1:8]};

    // Codes below CMD_JOY0 wrap to large values and fail the range test
    assign joy_idx    = io_data - frame_pkg::CMD_JOY0;
    assign cmd_joy    = joy_idx < 8'(frame_pkg::NPADS);
    assign cmd_status = io_data == frame_pkg::CMD_STATUS;

    assign last_byte = is_status ? (byte_cnt == 2'(frame_pkg::STATUS_BYTES - 1))
                                 : (byte_cnt == 2'(frame_pkg::JOY_BYTES - 1));

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            state    <= S_CMD;
            byte_cnt <= '0;
            status   <= '0;
            joy_q    <= '{default: '0};
        end else if (!io_frame) begin
            // A partial command is dropped when the frame ends
            state    <= S_CMD;
            byte_cnt <= '0;
        end else if (io_strobe) begin
            case (state)
                S_CMD: begin
                    byte_cnt <= '0;
                    state    <= (cmd_joy || cmd_status) ? S_DATA : S_SKIP;
                end
                S_DATA: begin
                    byte_cnt <= byte_cnt + 2'd1;
                    if (last_byte) begin
                        state <= S_SKIP;
                        if (is_status) begin
                            status <= shift_nx;
                        end else begin
                            joy_q[pad_sel] <= shift_nx[frame_pkg::STATUS_W-1 -: frame_pkg::RAW_W];
                        end
                    end
                end
                default: begin
                    // Extra bytes until the frame drops
                    state <= S_SKIP;
                end
            endcase
        end
    end

    // Command context and the assembly register
    always_ff @(posedge clk_sys) begin
        if (io_strobe) begin
            shift_q <= shift_nx;
            if (state == S_CMD) begin
                is_status <= cmd_status;
                pad_sel   <= joy_idx[SEL_W-1:0];
            end
        end
    end

    for (genvar i = 0; i < frame_pkg::NPADS; i++) begin : g_raw
        assign pads[i].raw = joy_q[i];
    end

    // Bytes only come inside a frame
    a_strobe_in_frame: assert property (
        @(posedge clk_sys) disable iff (!rst_n) io_strobe |-> io_frame
    );

endmodule

//--- design/joy_pad.sv
//////////////////////////////////////////////////////////////////////
// Joystick conditioner for one player. Rotates, flips and masks the
// raw word, then registers it in the game's polarity.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module joy_pad (
    input  logic clk_sys,
    input  logic rst_n,
    pad_if.pad   pad,
    input  logic rotate,
    input  logic flip
);

    // Released level of every game input
    localparam frame_pkg::joy_game_t IDLE = {frame_pkg::JOY_W{frame_pkg::GAME_ACTIVE_LOW}};
    // Directions plus the buttons the game reads
    localparam frame_pkg::joy_game_t BUT_MASK =
        frame_pkg::joy_game_t'((1 << (frame_pkg::JB_BUT0 + frame_pkg::BUTTONS)) - 1);

    logic                 rot_right, rot_left, rot_down, rot_up;
    frame_pkg::joy_game_t joy_act;

    always_comb begin
        if (rotate) begin
            // Quarter turn of the stick
            rot_right = pad.raw[frame_pkg::JB_UP];
            rot_down  = pad.raw[frame_pkg::JB_RIGHT];
            rot_left  = pad.raw[frame_pkg::JB_DOWN];
            rot_up    = pad.raw[frame_pkg::JB_LEFT];
        end else begin
            rot_right = pad.raw[frame_pkg::JB_RIGHT];
            rot_down  = pad.raw[frame_pkg::JB_DOWN];
            rot_left  = pad.raw[frame_pkg::JB_LEFT];
            rot_up    = pad.raw[frame_pkg::JB_UP];
        end

        joy_act = pad.raw[frame_pkg::JOY_W-1:0] & BUT_MASK;

        // Flip comes after rotation
        if (flip) begin
            joy_act[frame_pkg::JB_RIGHT] = rot_left;
            joy_act[frame_pkg::JB_LEFT]  = rot_right;
            joy_act[frame_pkg::JB_DOWN]  = rot_up;
            joy_act[frame_pkg::JB_UP]    = rot_down;
        end else begin
            joy_act[frame_pkg::JB_RIGHT] = rot_right;
            joy_act[frame_pkg::JB_LEFT]  = rot_left;
            joy_act[frame_pkg::JB_DOWN]  = rot_down;
            joy_act[frame_pkg::JB_UP]    = rot_up;
        end
    end

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            pad.joy     <= IDLE;
            pad.coin    <= frame_pkg::GAME_ACTIVE_LOW;
            pad.start   <= frame_pkg::GAME_ACTIVE_LOW;
            pad.service <= frame_pkg::GAME_ACTIVE_LOW;
        end else begin
            pad.joy     <= joy_act ^ IDLE;
            pad.coin    <= pad.raw[frame_pkg::JB_COIN] ^ frame_pkg::GAME_ACTIVE_LOW;
            pad.start   <= pad.raw[frame_pkg::JB_START] ^ frame_pkg::GAME_ACTIVE_LOW;
            pad.service <= pad.raw[frame_pkg::JB_SERVICE] ^ frame_pkg::GAME_ACTIVE_LOW;
        end
    end

    // An empty raw word from the receiver reads as released
    a_idle_on_zero: assert property (
        @(posedge clk_sys) disable iff (!rst_n)
        $past(pad.raw) == '0 |-> pad.joy == IDLE
    );

endmodule

//--- design/board_ctrl.sv
//////////////////////////////////////////////////////////////////////
// Board-level controls. Merges coin, start and service from all pads,
// decodes the DIP and menu bits and times the game reset.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module board_ctrl (
    input  logic                        clk_sys,
    input  logic                        rst_n,
    pad_if.board                        pads [frame_pkg::NPADS],
    input  frame_pkg::status_t          status,
    input  logic                        rst_req,
    output logic                        rotate,
    output logic                        flip,
    output logic [frame_pkg::NPADS-1:0] game_coin,
    output logic [frame_pkg::NPADS-1:0] game_start,
    output logic                        game_service,
    output logic                        dip_test,
    output logic                        dip_pause,
    output logic                        dip_flip,
    output logic [1:0]                  dip_fxlevel,
    output logic                        enable_fm,
    output logic                        enable_psg,
    output logic                        game_rst_n
);

    localparam logic [frame_pkg::NPADS-1:0] PADS_IDLE =
        {frame_pkg::NPADS{frame_pkg::GAME_ACTIVE_LOW}};

    logic [frame_pkg::NPADS-1:0]    pad_coin;
    logic [frame_pkg::NPADS-1:0]    pad_start;
    logic [frame_pkg::NPADS-1:0]    pad_service;
    logic                           svc_any;
    logic                           flip_prev;
    logic                           restart;
    logic [frame_pkg::RST_CNT_W-1:0] rst_cnt;

    for (genvar i = 0; i < frame_pkg::NPADS; i++) begin : g_collect
        assign pad_coin[i]    = pads[i].coin;
        assign pad_start[i]   = pads[i].start;
        assign pad_service[i] = pads[i].service;
    end

    // Service from any player counts
    assign svc_any = |(pad_service ^ PADS_IDLE);

    // Screen orientation goes straight to the pads
    assign rotate = status[frame_pkg::ST_ROTATE];
    assign flip   = status[frame_pkg::ST_FLIP];

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            game_coin    <= PADS_IDLE;
            game_start   <= PADS_IDLE;
            game_service <= frame_pkg::GAME_ACTIVE_LOW;
            dip_test     <= 1'b0;
            dip_pause    <= 1'b0;
            dip_flip     <= 1'b0;
            dip_fxlevel  <= 2'd0;
            enable_fm    <= 1'b1;
            enable_psg   <= 1'b1;
        end else begin
            game_coin    <= pad_coin;
            game_start   <= pad_start;
            game_service <= svc_any ^ frame_pkg::GAME_ACTIVE_LOW;
            dip_test     <= status[frame_pkg::ST_TEST];
            dip_pause    <= status[frame_pkg::ST_PAUSE];
            dip_flip     <= status[frame_pkg::ST_FLIP];
            dip_fxlevel  <= status[frame_pkg::ST_FXLEVEL +: 2];
            // Menu bits are disables
            enable_fm    <= ~status[frame_pkg::ST_FM];
            enable_psg   <= ~status[frame_pkg::ST_PSG];
        end
    end

    // A new screen orientation needs a fresh game start
    assign restart = rst_req || (dip_flip != flip_prev);

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            flip_prev  <= 1'b0;
            rst_cnt    <= frame_pkg::RST_CNT_W'(frame_pkg::RST_CYCLES);
            game_rst_n <= 1'b0;
        end else begin
            flip_prev <= dip_flip;
            if (restart) begin
                rst_cnt    <= frame_pkg::RST_CNT_W'(frame_pkg::RST_CYCLES);
                game_rst_n <= 1'b0;
            end else if (rst_cnt != '0) begin
                rst_cnt    <= rst_cnt - 1'b1;
                // Release on the final count
                game_rst_n <= rst_cnt == frame_pkg::RST_CNT_W'(1);
            end else begin
                game_rst_n <= 1'b1;
            end
        end
    end

    a_rst_while_counting: assert property (
        @(posedge clk_sys) disable iff (!rst_n) rst_cnt != '0 |-> !game_rst_n
    );

endmodule

//--- design/frame_ctrl_top.sv
//////////////////////////////////////////////////////////////////////
// Control-input frame top. Receiver, four pad conditioners and the
// board controller, joined by one pad bus per player.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module frame_ctrl_top (
    input  logic                        clk_sys,
    input  logic                        rst_n,
    // I/O controller byte stream
    input  logic [7:0]                  io_data,
    input  logic                        io_strobe,
    input  logic                        io_frame,
    // Reset request from the game
    input  logic                        rst_req,
    // Game inputs
    output frame_pkg::joy_game_t        game_joystick1,
    output frame_pkg::joy_game_t        game_joystick2,
    output frame_pkg::joy_game_t        game_joystick3,
    output frame_pkg::joy_game_t        game_joystick4,
    output logic [frame_pkg::NPADS-1:0] game_coin,
    output logic [frame_pkg::NPADS-1:0] game_start,
    output logic                        game_service,
    // DIP and menu settings
    output frame_pkg::status_t          status,
    output logic                        enable_fm,
    output logic                        enable_psg,
    output logic                        dip_test,
    output logic                        dip_pause,
    output logic                        dip_flip,
    output logic [1:0]                  dip_fxlevel,
    output logic                        game_rst_n
);

    logic rotate;
    logic flip;

    pad_if pad_bus [frame_pkg::NPADS] ();

    io_cmd_rx u_rx (
        .clk_sys    ( clk_sys     ),
        .rst_n      ( rst_n       ),
        .io_data    ( io_data     ),
        .io_strobe  ( io_strobe   ),
        .io_frame   ( io_frame    ),
        .pads       ( pad_bus     ),
        .status     ( status      )
    );

    for (genvar i = 0; i < frame_pkg::NPADS; i++) begin : g_pad
        joy_pad u_pad (
            .clk_sys    ( clk_sys     ),
            .rst_n      ( rst_n       ),
            .pad        ( pad_bus[i]  ),
            .rotate     ( rotate      ),
            .flip       ( flip        )
        );
    end

    board_ctrl u_board (
        .clk_sys      ( clk_sys      ),
        .rst_n        ( rst_n        ),
        .pads         ( pad_bus      ),
        .status       ( status       ),
        .rst_req      ( rst_req      ),
        .rotate       ( rotate       ),
        .flip         ( flip         ),
        .game_coin    ( game_coin    ),
        .game_start   ( game_start   ),
        .game_service ( game_service ),
        .dip_test     ( dip_test     ),
        .dip_pause    ( dip_pause    ),
        .dip_flip     ( dip_flip     ),
        .dip_fxlevel  ( dip_fxlevel  ),
        .enable_fm    ( enable_fm    ),
        .enable_psg   ( enable_psg   ),
        .game_rst_n   ( game_rst_n   )
    );

    assign game_joystick1 = pad_bus[0].joy;
    assign game_joystick2 = pad_bus[1].joy;
    assign game_joystick3 = pad_bus[2].joy;
    assign game_joystick4 = pad_bus[3].joy;

endmodule

//--- tb/tb_frame_ctrl.sv
//////////////////////////////////////////////////////////////////////
// Self-checking testbench for the control-input frame. Replays the
// records of the pattern file against the DUT, one operation each.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_frame_ctrl;

    localparam int MAX_WORDS = 256;

    logic                        clk_sys;
    logic                        rst_n;
    logic [7:0]                  io_data;
    logic                        io_strobe;
    logic                        io_frame;
    logic                        rst_req;
    frame_pkg::joy_game_t        joy [frame_pkg::NPADS];
    logic [frame_pkg::NPADS-1:0] game_coin;
    logic [frame_pkg::NPADS-1:0] game_start;
    logic                        game_service;
    frame_pkg::status_t          status;
    logic                        enable_fm;
    logic                        enable_psg;
    logic                        dip_test;
    logic                        dip_pause;
    logic                        dip_flip;
    logic [1:0]                  dip_fxlevel;
    logic                        game_rst_n;

    // Four words per record of op, code, data and expected
    logic [31:0] pat [MAX_WORDS];
    int          n_records = 0;
    integer      seed = 7;

    frame_ctrl_top u_dut (
        .clk_sys        ( clk_sys      ),
        .rst_n          ( rst_n        ),
        .io_data        ( io_data      ),
        .io_strobe      ( io_strobe    ),
        .io_frame       ( io_frame     ),
        .rst_req        ( rst_req      ),
        .game_joystick1 ( joy[0]       ),
        .game_joystick2 ( joy[1]       ),
        .game_joystick3 ( joy[2]       ),
        .game_joystick4 ( joy[3]       ),
        .game_coin      ( game_coin    ),
        .game_start     ( game_start   ),
        .game_service   ( game_service ),
        .status         ( status       ),
        .enable_fm      ( enable_fm    ),
        .enable_psg     ( enable_psg   ),
        .dip_test       ( dip_test     ),
        .dip_pause      ( dip_pause    ),
        .dip_flip       ( dip_flip     ),
        .dip_fxlevel    ( dip_fxlevel  ),
        .game_rst_n     ( game_rst_n   )
    );

    initial begin
        clk_sys = 1'b0;
        forever #5 clk_sys = ~clk_sys;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "Run stopped");
    endtask

    // One clock edge and then the input skew
    task automatic step();
        @(posedge clk_sys);
        #1;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
            abort_run("Output mismatch");
        end
    endtask

    task automatic send_byte(input logic [7:0] b);
        io_frame  = 1'b1;
        io_data   = b;
        io_strobe = 1'b1;
        step();
        io_strobe = 1'b0;
    endtask

    // Data goes out least significant byte first
    task automatic send_bytes(input int n, input logic [31:0] word);
        for (int i = 0; i < n; i++) begin
            send_byte(word[8*i +: 8]);
        end
    endtask

    task automatic check_joy(input int p, input logic [31:0] exp);
        check_value($sformatf("game_joystick%0d", p + 1), 32'(joy[p]), 32'(exp[9:0]));
    endtask

    task automatic check_buttons(input logic [31:0] exp);
        check_value("game_coin", 32'(game_coin), 32'(exp[19:16]));
        check_value("game_start", 32'(game_start), 32'(exp[23:20]));
        check_value("game_service", 32'(game_service), 32'(exp[24]));
    endtask

    task automatic check_status(input logic [31:0] data, input logic [31:0] exp);
        check_value("status", status, data);
        check_value("enable_fm", 32'(enable_fm), 32'(exp[0]));
        check_value("enable_psg", 32'(enable_psg), 32'(exp[1]));
        check_value("dip_test", 32'(dip_test), 32'(exp[2]));
        check_value("dip_pause", 32'(dip_pause), 32'(exp[3]));
        check_value("dip_flip", 32'(dip_flip), 32'(exp[4]));
        check_value("dip_fxlevel", 32'(dip_fxlevel), 32'(exp[6:5]));
    endtask

    // Waits briefly for game_rst_n to drop and counts the low cycles
    task automatic measure_reset(input logic [31:0] exp);
        int waited;
        int low_cycles;
        waited     = 0;
        low_cycles = 0;
        while (game_rst_n && waited < 8) begin
            step();
            waited++;
        end
        assert (!game_rst_n) else abort_run("Game reset did not drop when expected");
        while (!game_rst_n && low_cycles < 64) begin
            step();
            low_cycles++;
        end
        check_value("game_rst_n low cycles", low_cycles, exp);
    endtask

    initial begin
        logic [7:0]  op;
        logic [7:0]  code;
        logic [31:0] data;
        logic [31:0] exp;
        io_data   = 8'h00;
        io_strobe = 1'b0;
        io_frame  = 1'b0;
        rst_req   = 1'b0;
        rst_n     = 1'b0;
        $readmemh("tb/frame_patterns.hex", pat);
        while (n_records < MAX_WORDS / 4 && pat[4*n_records][7:0] != 8'h00) begin
            n_records++;
        end
        assert (n_records > 0) else abort_run("Pattern file is missing or empty");
        repeat (8) @(posedge clk_sys);
        #1 rst_n = 1'b1;

        for (int r = 0; r < n_records; r++) begin
            op   = pat[4*r][7:0];
            code = pat[4*r+1][7:0];
            data = pat[4*r+2];
            exp  = pat[4*r+3];
            case (op)
                8'h01: begin
                    send_byte(8'(frame_pkg::CMD_JOY0 + code));
                    send_bytes(2, data);
                    io_frame = 1'b0;
                    step();
                    check_joy(code, exp);
                    step();
                    check_buttons(exp);
                end
                8'h02: begin
                    send_byte(frame_pkg::CMD_STATUS);
                    send_bytes(4, data);
                    io_frame = 1'b0;
                    step();
                    check_status(data, exp);
                end
                8'h03: begin
                    rst_req = 1'b1;
                    step();
                    rst_req = 1'b0;
                    measure_reset(exp);
                end
                8'h04: measure_reset(exp);
                8'h05: begin
                    // Raw frame followed by random junk bytes in the same frame
                    send_bytes(code, data);
                    repeat (exp) send_byte(8'($random(seed)));
                    io_frame = 1'b0;
                    repeat (3) step();
                end
                8'h06: begin
                    check_joy(code, exp);
                    check_buttons(exp);
                end
                8'h07: check_status(data, exp);
                default: abort_run("Unknown operation in the pattern file");
            endcase
        end
        $display("Verification passed");
        $finish;
    end

    // Record count is final once reset releases
    initial begin
        @(posedge rst_n);
        repeat (n_records * 40 + 500) @(posedge clk_sys);
        abort_run("Timeout, the tests did not finish in time");
    end

endmodule

//--- tb/frame_patterns.hex
// op code data expected. op 01 joy, 02 status, 03 rst_req, 04 reset length, 05 raw frame
// (code = bytes, expected = junk count), 06 pad check, 07 status check, 00 end
04 00 00000000 00000010
06 00 00000000 01FF03FF
06 03 00000000 01FF03FF
07 00 00000000 00000003
01 00 00000A35 01FE03CA
01 01 00000748 01DE03B7
01 02 00001090 00DE036F
01 03 00000C03 005603FC
02 00 A5C300CD 0000006E
02 00 00000042 00000021
01 00 00000001 005703FE
02 00 00000020 00000003
06 00 00000000 005703FB
02 00 00000030 00000013
04 00 00000000 00000010
06 00 00000000 005703F7
01 01 00000008 007703FD
01 02 00000002 017703FB
02 00 00000000 00000003
04 00 00000000 00000010
03 00 00000000 00000010
05 02 00005503 00000000
05 01 00000007 00000006
05 03 00000102 00000005
06 01 00000000 017703F7
07 00 00000000 00000003
00 00 00000000 00000000

//--- all.f
design/frame_pkg.sv
design/pad_if.sv
design/io_cmd_rx.sv
design/joy_pad.sv
design/board_ctrl.sv
design/frame_ctrl_top.sv
tb/tb_frame_ctrl.sv

//--- Makefile
# Verilator build and run of the control-input frame testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, result taken from sim.log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f all.f \
		--top-module tb_frame_ctrl -Mdir obj_dir
	-./obj_dir/Vtb_frame_ctrl > sim.log 2>&1
	@cat sim.log
	@if grep -q "Verification passed" sim.log; then echo "PASS"; \
	else echo "FAIL"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
